//--- project.f
rs_pkg.sv
rs_occupancy.sv
rs_wakeup.sv
rs_station.sv
rs_top.sv
rs_chk.sv
tb_rs.sv

//--- run.sh
#!/bin/sh
# build and run the issue buffer regression with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f project.f --top-module tb_rs -o sim_rs

./obj_dir/sim_rs > sim.log 2>&1 || true
cat sim.log

if grep -q "Regression passed" sim.log
then
    exit 0
fi
exit 1

//--- tb_rs.sv
`timescale 1ns/1ns

module tb_rs;
    import rs_pkg::*;

    localparam int NUM_DISPATCH = 37;
    localparam int CYCLE_LIMIT  = 20 * NUM_DISPATCH + 100;
    localparam int ENTRY_W      = 3 * PREG_W + AREG_W + ROB_W + DECODE_W;

    logic                clk;
    logic                rst;
    logic                dispatch_valid;
    logic [SEL_W-1:0]    rs_select;
    logic [PREG_W-1:0]   ps1;
    logic [PREG_W-1:0]   ps2;
    logic                ps1_ready;
    logic                ps2_ready;
    logic [AREG_W-1:0]   rd;
    logic [PREG_W-1:0]   pd;
    logic [ROB_W-1:0]    rob_entry;
    logic [DECODE_W-1:0] decode_info;
    logic [PREG_W-1:0]   cdb_tag_add;
    logic [PREG_W-1:0]   cdb_tag_mul;
    logic                add_fu_busy;
    logic                mul_fu_busy;
    logic                add_fu_ready;
    logic                mul_fu_ready;
    logic [PREG_W-1:0]   add_issue_ps1;
    logic [PREG_W-1:0]   add_issue_ps2;
    logic [PREG_W-1:0]   add_issue_pd;
    logic [PREG_W-1:0]   mul_issue_ps1;
    logic [PREG_W-1:0]   mul_issue_ps2;
    logic [PREG_W-1:0]   mul_issue_pd;
    logic [AREG_W-1:0]   add_issue_rd;
    logic [AREG_W-1:0]   mul_issue_rd;
    logic [ROB_W-1:0]    add_issue_rob;
    logic [ROB_W-1:0]    mul_issue_rob;
    logic [DECODE_W-1:0] add_issue_decode;
    logic [DECODE_W-1:0] mul_issue_decode;
    logic                add_full;
    logic                mul_full;

    logic [ENTRY_W-1:0] add_issue_all; // all issue fields of one unit
    logic [ENTRY_W-1:0] mul_issue_all;

    logic [ENTRY_W-1:0] add_q[$]; // expected entries, slot order
    logic [ENTRY_W-1:0] mul_q[$];
    int add_count = 0;           // model of slots in use
    int mul_count = 0;
    int errors    = 0;
    int misses    = 0;
    int cycles    = 0;
    int seed      = 90517;

    rs_top dut_i (.*);

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [ENTRY_W-1:0] pack_entry(
        input logic [PREG_W-1:0] e_ps1, input logic [PREG_W-1:0] e_ps2,
        input logic [PREG_W-1:0] e_pd, input logic [AREG_W-1:0] e_rd,
        input logic [ROB_W-1:0] e_rob, input logic [DECODE_W-1:0] e_dec);
        return {e_ps1, e_ps2, e_pd, e_rd, e_rob, e_dec};
    endfunction

    assign add_issue_all = pack_entry(add_issue_ps1, add_issue_ps2, add_issue_pd,
                                      add_issue_rd, add_issue_rob, add_issue_decode);
    assign mul_issue_all = pack_entry(mul_issue_ps1, mul_issue_ps2, mul_issue_pd,
                                      mul_issue_rd, mul_issue_rob, mul_issue_decode);

    task automatic compare_issue(input string unit, input logic [ENTRY_W-1:0] got,
                                 input logic [ENTRY_W-1:0] exp);
        assert (got == exp)
        else
        begin
            errors++;
            $display("** Error %s_issue {ps1,ps2,pd,rd,rob,decode}: got %h expected %h",
                     unit, got, exp);
        end
    endtask

    task automatic compare_full(input string unit, input logic got, input int count,
                                input int depth);
        assert (got == (count == depth))
        else
        begin
            errors++;
            $display("** Error %s_full: got %h expected %h", unit, got, count == depth);
        end
    endtask

    // scoreboard, sampled before the edge updates the DUT
    always @(posedge clk)
    begin
        cycles++;
        if (!rst)
        begin
            compare_full("add", add_full, add_count, ADD_DEPTH);
            compare_full("mul", mul_full, mul_count, MUL_DEPTH);
            if (add_fu_ready)
            begin
                if (add_q.size() == 0)
                begin
                    errors++;
                    $display("add station issued with nothing expected");
                end
                else
                begin
                    compare_issue("add", add_issue_all, add_q.pop_front());
                end
                add_count--;
            end
            else
            begin
                compare_issue("add", add_issue_all, '0); // idle fields read as zero
            end
            if (mul_fu_ready)
            begin
                if (mul_q.size() == 0)
                begin
                    errors++;
                    $display("mul station issued with nothing expected");
                end
                else
                begin
                    compare_issue("mul", mul_issue_all, mul_q.pop_front());
                end
                mul_count--;
            end
            else
            begin
                compare_issue("mul", mul_issue_all, '0);
            end
            // full is judged on the count before this edge
            if (dispatch_valid && rs_select == SEL_ADD && add_count + (add_fu_ready ? 1 : 0)
                < ADD_DEPTH)
            begin
                add_q.push_back(pack_entry(ps1, ps2, pd, rd, rob_entry, decode_info));
                add_count++;
            end
            if (dispatch_valid && rs_select == SEL_MUL && mul_count + (mul_fu_ready ? 1 : 0)
                < MUL_DEPTH)
            begin
                mul_q.push_back(pack_entry(ps1, ps2, pd, rd, rob_entry, decode_info));
                mul_count++;
            end
        end
        if (cycles >= CYCLE_LIMIT)
        begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            misses++;
            finish_run();
        end
    end

    task automatic finish_run();
        int total;
        total = errors + misses + dut_i.chk_i.fail_count;
        $display("value errors %0d, missed %0d, assertion failures %0d",
                 errors, misses, dut_i.chk_i.fail_count);
        if (total == 0)
        begin
            $display("Regression passed");
        end
        else
        begin
            $display("Regression failed");
        end
        $finish;
    endtask

    task automatic dispatch(input logic [SEL_W-1:0] sel, input logic [PREG_W-1:0] s1,
                            input logic [PREG_W-1:0] s2, input logic r1, input logic r2);
        int r;
        @(negedge clk);
        r              = $random(seed);
        dispatch_valid = 1'b1;
        rs_select      = sel;
        ps1            = s1;
        ps2            = s2;
        ps1_ready      = r1;
        ps2_ready      = r2;
        pd             = r[5:0];
        rd             = r[10:6];
        rob_entry      = r[16:11];
        decode_info    = r[31:16];
        @(negedge clk);
        dispatch_valid = 1'b0;
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while ((add_q.size() != 0 || mul_q.size() != 0) && n < 40)
        begin
            @(negedge clk);
            n++;
        end
        if (add_q.size() != 0 || mul_q.size() != 0)
        begin
            misses++;
            $display("timeout: dispatched entries never issued");
            add_q.delete();
            mul_q.delete();
        end
    endtask

    initial
    begin
        int r;
        rst            = 1'b1;
        dispatch_valid = 1'b0;
        rs_select      = SEL_ADD;
        {ps1, ps2, pd, rd, rob_entry, decode_info} = '0;
        {ps1_ready, ps2_ready} = 2'b11;
        cdb_tag_add = '0;
        cdb_tag_mul = '0;
        add_fu_busy = 1'b0;
        mul_fu_busy = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // ready entries go out in the next cycle
        dispatch(SEL_ADD, 6'd5, 6'd6, 1'b1, 1'b1);
        dispatch(SEL_MUL, 6'd7, 6'd8, 1'b1, 1'b1);
        wait_drain();

        // held by busy, then one per cycle
        add_fu_busy = 1'b1;
        repeat (3) dispatch(SEL_ADD, 6'd3, 6'd4, 1'b1, 1'b1);
        repeat (2) @(negedge clk);
        add_fu_busy = 1'b0;
        wait_drain();

        // fill with waiting entries, fifth one dropped
        repeat (5) dispatch(SEL_ADD, 6'd9, 6'd0, 1'b0, 1'b1);
        cdb_tag_add = 6'd9;
        @(negedge clk);
        cdb_tag_add = '0;
        wait_drain();

        // mul bus must not wake an add entry
        dispatch(SEL_ADD, 6'd12, 6'd0, 1'b0, 1'b1);
        cdb_tag_mul = 6'd12;
        @(negedge clk);
        cdb_tag_mul = '0;
        repeat (4)
        begin
            @(negedge clk);
            if (add_fu_ready)
            begin
                errors++;
                $display("add entry woken by the mul result bus");
            end
        end
        cdb_tag_add = 6'd12;
        @(negedge clk);
        cdb_tag_add = '0;
        wait_drain();

        // both units released together
        add_fu_busy = 1'b1;
        mul_fu_busy = 1'b1;
        dispatch(SEL_ADD, 6'd1, 6'd2, 1'b1, 1'b1);
        dispatch(SEL_MUL, 6'd1, 6'd2, 1'b1, 1'b1);
        add_fu_busy = 1'b0;
        mul_fu_busy = 1'b0;
        @(posedge clk);
        if (!(add_fu_ready && mul_fu_ready))
        begin
            errors++;
            $display("add and mul stations did not issue in the same cycle");
        end
        wait_drain();

        // random selects, code 2 goes nowhere
        repeat (24)
        begin
            r = $random(seed);
            dispatch(SEL_W'(r[7:0] % 3), r[13:8], r[19:14], 1'b1, 1'b1);
        end
        wait_drain();
        repeat (4) @(negedge clk);
        finish_run();
    end

endmodule : tb_rs

//--- rs_chk.sv
`timescale 1ns/1ns

// timing properties of the issue buffer, bound into rs_top
module rs_chk (
    input logic                                          clk,
    input logic                                          rst,
    input logic                                          dispatch_valid,
    input logic [rs_pkg::SEL_W-1:0]                      rs_select,
    input logic                                          ps1_ready,
    input logic                                          ps2_ready,
    input logic [rs_pkg::PREG_W-1:0]                     cdb_tag_add,
    input logic                                          add_fu_busy,
    input logic                                          mul_fu_busy,
    input logic                                          add_fu_ready,
    input logic                                          mul_fu_ready,
    input logic                                          add_full,
    input logic                                          mul_full,
    input logic [rs_pkg::ADD_DEPTH-1:0]                  add_valid,
    input logic [rs_pkg::ADD_DEPTH-1:0][rs_pkg::PREG_W-1:0] add_slot_ps1,
    input logic [rs_pkg::ADD_DEPTH-1:0][rs_pkg::PREG_W-1:0] add_slot_ps2,
    input logic [rs_pkg::ADD_DEPTH-1:0]                  add_rdy1,
    input logic [rs_pkg::ADD_DEPTH-1:0]                  add_rdy2,
    input logic [rs_pkg::PREG_W-1:0]                     add_tag_q
);
    import rs_pkg::*;

    int   fail_count = 0;
    logic add_take;
    logic mul_take;
    logic add_wake; // some add entry completes on the tag seen now

    assign add_take = dispatch_valid && (rs_select == SEL_ADD) && !add_full;
    assign mul_take = dispatch_valid && (rs_select == SEL_MUL) && !mul_full;

    always_comb
    begin
        add_wake = 1'b0;
        for (int i = 0; i < ADD_DEPTH; i++)
        begin
            if (add_valid[i] && !(add_rdy1[i] && add_rdy2[i])
                && (add_rdy1[i] || (add_slot_ps1[i] == cdb_tag_add))
                && (add_rdy2[i] || (add_slot_ps2[i] == cdb_tag_add)))
            begin
                add_wake = 1'b1;
            end
        end
        if (add_tag_q == cdb_tag_add)
        begin
            add_wake = 1'b0; // already matched one edge earlier
        end
    end

    a_reset_idle: assert property (@(posedge clk)
        $fell(rst) |-> !add_fu_ready && !mul_fu_ready && !add_full && !mul_full)
    else
    begin
        fail_count++;
        $error("station not idle after reset");
    end

    a_add_next: assert property (@(posedge clk) disable iff (rst)
        add_take && ps1_ready && ps2_ready |=> add_fu_ready || add_fu_busy)
    else
    begin
        fail_count++;
        $error("ready add entry not offered in the next cycle");
    end

    a_mul_next: assert property (@(posedge clk) disable iff (rst)
        mul_take && ps1_ready && ps2_ready |=> mul_fu_ready || mul_fu_busy)
    else
    begin
        fail_count++;
        $error("ready mul entry not offered in the next cycle");
    end

    a_add_busy: assert property (@(posedge clk) disable iff (rst)
        add_fu_busy |-> !add_fu_ready)
    else
    begin
        fail_count++;
        $error("add issue while unit busy");
    end

    a_mul_busy: assert property (@(posedge clk) disable iff (rst)
        mul_fu_busy |-> !mul_fu_ready)
    else
    begin
        fail_count++;
        $error("mul issue while unit busy");
    end

    a_add_wake: assert property (@(posedge clk) disable iff (rst)
        add_wake |-> ##2 (add_fu_ready || add_fu_busy))
    else
    begin
        fail_count++;
        $error("add wakeup not seen two cycles after the tag");
    end

endmodule : rs_chk

bind rs_top rs_chk chk_i (
    .clk            (clk),
    .rst            (rst),
    .dispatch_valid (dispatch_valid),
    .rs_select      (rs_select),
    .ps1_ready      (ps1_ready),
    .ps2_ready      (ps2_ready),
    .cdb_tag_add    (cdb_tag_add),
    .add_fu_busy    (add_fu_busy),
    .mul_fu_busy    (mul_fu_busy),
    .add_fu_ready   (add_fu_ready),
    .mul_fu_ready   (mul_fu_ready),
    .add_full       (add_full),
    .mul_full       (mul_full),
    .add_valid      (add_rs_i.valid_q),
    .add_slot_ps1   (add_rs_i.ps1_q),
    .add_slot_ps2   (add_rs_i.ps2_q),
    .add_rdy1       (add_rs_i.wake_i.rdy1_q),
    .add_rdy2       (add_rs_i.wake_i.rdy2_q),
    .add_tag_q      (add_rs_i.wake_i.tag_q)
);

//--- rs_top.sv
`timescale 1ns/1ns

// issue buffer: add and multiply stations side by side
module rs_top (
    input  logic                          clk,
    input  logic                          rst,
    // dispatch
    input  logic                          dispatch_valid,
    input  logic [rs_pkg::SEL_W-1:0]      rs_select,
    input  logic [rs_pkg::PREG_W-1:0]     ps1,
    input  logic [rs_pkg::PREG_W-1:0]     ps2,
    input  logic                          ps1_ready,
    input  logic                          ps2_ready,
    input  logic [rs_pkg::AREG_W-1:0]     rd,
    input  logic [rs_pkg::PREG_W-1:0]     pd,
    input  logic [rs_pkg::ROB_W-1:0]      rob_entry,
    input  logic [rs_pkg::DECODE_W-1:0]   decode_info,
    // result buses, one per unit
    input  logic [rs_pkg::PREG_W-1:0]     cdb_tag_add,
    input  logic [rs_pkg::PREG_W-1:0]     cdb_tag_mul,
    input  logic                          add_fu_busy,
    input  logic                          mul_fu_busy,
    // adder side
    output logic                          add_fu_ready,
    output logic [rs_pkg::PREG_W-1:0]     add_issue_ps1,
    output logic [rs_pkg::PREG_W-1:0]     add_issue_ps2,
    output logic [rs_pkg::PREG_W-1:0]     add_issue_pd,
    output logic [rs_pkg::AREG_W-1:0]     add_issue_rd,
    output logic [rs_pkg::ROB_W-1:0]      add_issue_rob,
    output logic [rs_pkg::DECODE_W-1:0]   add_issue_decode,
    output logic                          add_full,
    // multiplier side
    output logic                          mul_fu_ready,
    output logic [rs_pkg::PREG_W-1:0]     mul_issue_ps1,
    output logic [rs_pkg::PREG_W-1:0]     mul_issue_ps2,
    output logic [rs_pkg::PREG_W-1:0]     mul_issue_pd,
    output logic [rs_pkg::AREG_W-1:0]     mul_issue_rd,
    output logic [rs_pkg::ROB_W-1:0]      mul_issue_rob,
    output logic [rs_pkg::DECODE_W-1:0]   mul_issue_decode,
    output logic                          mul_full
);
    import rs_pkg::*;

    rs_station #(
        .DEPTH    (ADD_DEPTH),
        .SEL_CODE (SEL_ADD)
    ) add_rs_i (
        .clk            (clk),
        .rst            (rst),
        .dispatch_valid (dispatch_valid),
        .rs_select      (rs_select),
        .ps1            (ps1),
        .ps2            (ps2),
        .pd             (pd),
        .ps1_ready      (ps1_ready),
        .ps2_ready      (ps2_ready),
        .rd             (rd),
        .rob_entry      (rob_entry),
        .decode_info    (decode_info),
        .cdb_tag        (cdb_tag_add),
        .fu_busy        (add_fu_busy),
        .fu_ready       (add_fu_ready),
        .issue_ps1      (add_issue_ps1),
        .issue_ps2      (add_issue_ps2),
        .issue_pd       (add_issue_pd),
        .issue_rd       (add_issue_rd),
        .issue_rob      (add_issue_rob),
        .issue_decode   (add_issue_decode),
        .full           (add_full)
    );

    rs_station #(
        .DEPTH    (MUL_DEPTH),
        .SEL_CODE (SEL_MUL)
    ) mul_rs_i (
        .clk            (clk),
        .rst            (rst),
        .dispatch_valid (dispatch_valid),
        .rs_select      (rs_select),
        .ps1            (ps1),
        .ps2            (ps2),
        .pd             (pd),
        .ps1_ready      (ps1_ready),
        .ps2_ready      (ps2_ready),
        .rd             (rd),
        .rob_entry      (rob_entry),
        .decode_info    (decode_info),
        .cdb_tag        (cdb_tag_mul), // mul bus only wakes mul entries
        .fu_busy        (mul_fu_busy),
        .fu_ready       (mul_fu_ready),
        .issue_ps1      (mul_issue_ps1),
        .issue_ps2      (mul_issue_ps2),
        .issue_pd       (mul_issue_pd),
        .issue_rd       (mul_issue_rd),
        .issue_rob      (mul_issue_rob),
        .issue_decode   (mul_issue_decode),
        .full           (mul_full)
    );

endmodule : rs_top

//--- rs_station.sv
`timescale 1ns/1ns

// one reservation station: storage, slot pick and issue to its unit
module rs_station #(
    parameter int                         DEPTH    = rs_pkg::ADD_DEPTH,
    parameter logic [rs_pkg::SEL_W-1:0]   SEL_CODE = rs_pkg::SEL_ADD
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          dispatch_valid,
    input  logic [rs_pkg::SEL_W-1:0]      rs_select,
    input  logic [rs_pkg::PREG_W-1:0]     ps1,
    input  logic [rs_pkg::PREG_W-1:0]     ps2,
    input  logic [rs_pkg::PREG_W-1:0]     pd,
    input  logic                          ps1_ready,
    input  logic                          ps2_ready,
    input  logic [rs_pkg::AREG_W-1:0]     rd,
    input  logic [rs_pkg::ROB_W-1:0]      rob_entry,
    input  logic [rs_pkg::DECODE_W-1:0]   decode_info,
    input  logic [rs_pkg::PREG_W-1:0]     cdb_tag,
    input  logic                          fu_busy,
    output logic                          fu_ready,
    output logic [rs_pkg::PREG_W-1:0]     issue_ps1,
    output logic [rs_pkg::PREG_W-1:0]     issue_ps2,
    output logic [rs_pkg::PREG_W-1:0]     issue_pd,
    output logic [rs_pkg::AREG_W-1:0]     issue_rd,
    output logic [rs_pkg::ROB_W-1:0]      issue_rob,
    output logic [rs_pkg::DECODE_W-1:0]   issue_decode,
    output logic                          full
);
    import rs_pkg::*;

    localparam int IDX_W = $clog2(DEPTH);

    // entry storage
    logic [DEPTH-1:0]                valid_q;
    logic [DEPTH-1:0][PREG_W-1:0]    ps1_q;
    logic [DEPTH-1:0][PREG_W-1:0]    ps2_q;
    logic [DEPTH-1:0][PREG_W-1:0]    pd_q;
    logic [DEPTH-1:0][AREG_W-1:0]    rd_q;
    logic [DEPTH-1:0][ROB_W-1:0]     rob_q;
    logic [DEPTH-1:0][DECODE_W-1:0]  decode_q;

    logic [DEPTH-1:0]  ready;       // both operands ready, from wakeup
    logic              insert;
    logic [IDX_W-1:0]  free_slot;
    logic              free_found;
    logic [IDX_W-1:0]  issue_slot;
    logic              issue_found;

    // full is judged on the state before the edge
    assign insert = dispatch_valid && (rs_select == SEL_CODE) && !full;

    // lowest free slot
    always_comb
    begin
        free_slot  = '0;
        free_found = 1'b0;
        for (int i = 0; i < DEPTH; i++)
        begin
            if (!valid_q[i] && !free_found)
            begin
                free_slot  = IDX_W'(i);
                free_found = 1'b1;
            end
        end
    end

    // lowest valid slot with both operands ready
    always_comb
    begin
        issue_slot  = '0;
        issue_found = 1'b0;
        for (int i = 0; i < DEPTH; i++)
        begin
            if (valid_q[i] && ready[i] && !issue_found)
            begin
                issue_slot  = IDX_W'(i);
                issue_found = 1'b1;
            end
        end
    end

    assign fu_ready = issue_found && !fu_busy;

    // issue fields read as zero unless an entry goes out
    always_comb
    begin
        issue_ps1    = '0;
        issue_ps2    = '0;
        issue_pd     = '0;
        issue_rd     = '0;
        issue_rob    = '0;
        issue_decode = '0;
        if (fu_ready)
        begin
            issue_ps1    = ps1_q[issue_slot];
            issue_ps2    = ps2_q[issue_slot];
            issue_pd     = pd_q[issue_slot];
            issue_rd     = rd_q[issue_slot];
            issue_rob    = rob_q[issue_slot];
            issue_decode = decode_q[issue_slot];
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            valid_q <= '0;
        end
        else
        begin
            if (fu_ready)
            begin
                valid_q[issue_slot] <= 1'b0;
            end
            if (insert && free_found)
            begin
                valid_q[free_slot] <= 1'b1; // never the issuing slot
            end
        end
    end

    // payload only, no reset
    always_ff @(posedge clk)
    begin
        if (insert && free_found)
        begin
            ps1_q[free_slot]    <= ps1;
            ps2_q[free_slot]    <= ps2;
            pd_q[free_slot]     <= pd;
            rd_q[free_slot]     <= rd;
            rob_q[free_slot]    <= rob_entry;
            decode_q[free_slot] <= decode_info;
        end
    end

    rs_occupancy #(
        .DEPTH (DEPTH)
    ) occ_i (
        .clk    (clk),
        .rst    (rst),
        .insert (insert),
        .issue  (fu_ready),
        .full   (full)
    );

    rs_wakeup #(
        .DEPTH (DEPTH)
    ) wake_i (
        .clk         (clk),
        .rst         (rst),
        .cdb_tag     (cdb_tag),
        .insert      (insert),
        .insert_slot (free_slot),
        .ps1         (ps1),
        .ps2         (ps2),
        .ps1_ready   (ps1_ready),
        .ps2_ready   (ps2_ready),
        .slot_ps1    (ps1_q),
        .slot_ps2    (ps2_q),
        .issue       (fu_ready),
        .issue_slot  (issue_slot),
        .ready       (ready)
    );

endmodule : rs_station

//--- rs_wakeup.sv
`timescale 1ns/1ns

// operand ready bits of one station, woken by its own result bus
module rs_wakeup #(
    parameter int DEPTH = rs_pkg::ADD_DEPTH
) (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic [rs_pkg::PREG_W-1:0]             cdb_tag,
    input  logic                                  insert,
    input  logic [$clog2(DEPTH)-1:0]              insert_slot,
    input  logic [rs_pkg::PREG_W-1:0]             ps1,
    input  logic [rs_pkg::PREG_W-1:0]             ps2,
    input  logic                                  ps1_ready,
    input  logic                                  ps2_ready,
    input  logic [DEPTH-1:0][rs_pkg::PREG_W-1:0]  slot_ps1, // stored source tags
    input  logic [DEPTH-1:0][rs_pkg::PREG_W-1:0]  slot_ps2,
    input  logic                                  issue,
    input  logic [$clog2(DEPTH)-1:0]              issue_slot,
    output logic [DEPTH-1:0]                      ready
);
    import rs_pkg::*;

    logic [PREG_W-1:0] tag_q;   // result bus tag, one cycle late
    logic [DEPTH-1:0]  rdy1_q;
    logic [DEPTH-1:0]  rdy2_q;
    logic              ins_rdy1;
    logic              ins_rdy2;

    // sampled in reset too, so the first tag after reset is not missed
    always_ff @(posedge clk)
    begin
        tag_q <= cdb_tag;
    end

    // new entry also catches a tag that is matching this edge
    assign ins_rdy1 = ps1_ready || (ps1 == tag_q);
    assign ins_rdy2 = ps2_ready || (ps2 == tag_q);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            rdy1_q <= '0;
            rdy2_q <= '0;
        end
        else
        begin
            for (int i = 0; i < DEPTH; i++)
            begin
                if (insert && (insert_slot == $clog2(DEPTH)'(i)))
                begin
                    rdy1_q[i] <= ins_rdy1;
                    rdy2_q[i] <= ins_rdy2;
                end
                else if (issue && (issue_slot == $clog2(DEPTH)'(i)))
                begin
                    rdy1_q[i] <= 1'b0; // slot freed
                    rdy2_q[i] <= 1'b0;
                end
                else
                begin
                    if (slot_ps1[i] == tag_q)
                    begin
                        rdy1_q[i] <= 1'b1;
                    end
                    if (slot_ps2[i] == tag_q)
                    begin
                        rdy2_q[i] <= 1'b1;
                    end
                end
            end
        end
    end

    // a freed slot can be re-woken by a stale tag, the station masks with valid
    assign ready = rdy1_q & rdy2_q;

endmodule : rs_wakeup

//--- rs_occupancy.sv
`timescale 1ns/1ns

// tracks how many slots of one station hold an entry
module rs_occupancy #(
    parameter int DEPTH = rs_pkg::ADD_DEPTH
) (
    input  logic clk,
    input  logic rst,
    input  logic insert, // entry written this edge
    input  logic issue,  // entry leaves this edge
    output logic full
);

    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [CNT_W-1:0] count;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            count <= '0;
        end
        else
        begin
            // insert and issue on the same edge cancel out
            case ({insert, issue})
                2'b10:   count <= count + CNT_W'(1);
                2'b01:   count <= count - CNT_W'(1);
                default: count <= count;
            endcase
        end
    end

    assign full = (count == CNT_W'(DEPTH));

endmodule : rs_occupancy

//--- rs_pkg.sv
package rs_pkg;

    // tag and index widths
    localparam int PREG_W   = 6;  // physical register tag
    localparam int AREG_W   = 5;  // architectural register number
    localparam int ROB_W    = 6;  // reorder buffer index
    localparam int DECODE_W = 16; // decode word, passed through untouched

    // station select from dispatch
    localparam int SEL_W = 2;

    // only add and mul exist, codes 2 and 3 go nowhere
    localparam logic [SEL_W-1:0] SEL_ADD = 2'd0;
    localparam logic [SEL_W-1:0] SEL_MUL = 2'd1;

    // slots per station
    localparam int ADD_DEPTH = 4;
    localparam int MUL_DEPTH = 4;

endpackage : rs_pkg
